//--- hdl/ecc_macros.svh
// ecc channel widths and constants
`ifndef ECC_MACROS_SVH
`define ECC_MACROS_SVH

// payload bits per word
`define ECC_DATA_W 8

// hsiao check bits for 8 data bits
`define ECC_PAR_W 5

// parity field over data field
`define ECC_CW_W 13

// data_valid to dec_valid, enc 1 + inj 1 + dec 2
`define ECC_PIPE_LATENCY 4

// monitor event counter width
`define ECC_CNT_W 16

`endif

//--- hdl/ecc_code_pkg.sv
// hsiao secded check matrix
`default_nettype none
`include "ecc_macros.svh"

package ecc_code_pkg;

  // one column per codeword bit, index = flat bit position
  // data columns are distinct weight-3 vectors
  // parity columns are unit vectors, so check bit i covers itself only
  parameter logic [`ECC_PAR_W-1:0] HCOL [`ECC_CW_W] = '{
    5'b00111, 5'b01011, 5'b01101, 5'b01110,
    5'b10011, 5'b10101, 5'b10110, 5'b11001,
    5'b00001, 5'b00010, 5'b00100, 5'b01000,
    5'b10000
  };

  // check bits for a data word
  function automatic logic [`ECC_PAR_W-1:0] calc_parity(
    input logic [`ECC_DATA_W-1:0] data
  );
    logic [`ECC_PAR_W-1:0] p;
    p = '0;
    // xor in the column of every set data bit
    for (int i = 0; i < `ECC_DATA_W; i++) begin
      if (data[i]) begin
        p ^= HCOL[i];
      end
    end
    return p;
  endfunction

  // syndrome over the whole received codeword
  function automatic logic [`ECC_PAR_W-1:0] calc_syndrome(
    input logic [`ECC_CW_W-1:0] cw
  );
    logic [`ECC_PAR_W-1:0] s;
    s = '0;
    // zero for any clean codeword, else xor of flipped columns
    for (int i = 0; i < `ECC_CW_W; i++) begin
      if (cw[i]) begin
        s ^= HCOL[i];
      end
    end
    return s;
  endfunction

endpackage

`default_nettype wire

//--- hdl/ecc_types_pkg.sv
// ecc word layout types
`default_nettype none
`include "ecc_macros.svh"

package ecc_types_pkg;

  // field view, parity sits above data
  typedef struct packed {
    logic [`ECC_PAR_W-1:0]  parity;
    logic [`ECC_DATA_W-1:0] data;
  } cw_fields_t;

  // same 13 bits seen two ways
  // f for encode and data extraction
  // bits for fault masks and correction by position
  typedef union packed {
    cw_fields_t            f;
    logic [`ECC_CW_W-1:0]  bits;
  } codeword_u;

  // one bit per check row
  typedef logic [`ECC_PAR_W-1:0] syndrome_t;

endpackage

`default_nettype wire

//--- hdl/secded_encoder.sv
// secded encoder
`timescale 1ns/1ps
`default_nettype none
`include "ecc_macros.svh"

module secded_encoder (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     data_valid,
  input  logic [`ECC_DATA_W-1:0]   data,
  output logic                     enc_valid,
  output ecc_types_pkg::codeword_u enc_codeword
);

  // codeword before the output register
  ecc_types_pkg::codeword_u cw_next;

  always_comb begin
    cw_next.f.data   = data;
    cw_next.f.parity = ecc_code_pkg::calc_parity(data);
  end

  // valid strobe, one cycle behind data_valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enc_valid <= 1'b0;
    end else begin
      enc_valid <= data_valid;
    end
  end

  // payload only loads with a word
  always_ff @(posedge clk) begin
    if (data_valid) begin
      enc_codeword <= cw_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/error_injector.sv
// codeword fault injector
`timescale 1ns/1ps
`default_nettype none
`include "ecc_macros.svh"

module error_injector (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     data_valid,
  input  logic [`ECC_CW_W-1:0]     flip_mask,
  input  logic                     enc_valid,
  input  ecc_types_pkg::codeword_u enc_codeword,
  output logic                     rcv_valid,
  output ecc_types_pkg::codeword_u rcv_codeword
);

  // mask taken with the data word, meets its codeword next cycle
  logic [`ECC_CW_W-1:0] mask_q;

  always_ff @(posedge clk) begin
    if (data_valid) begin
      mask_q <= flip_mask;
    end
    // flips applied by flat bit position
    if (enc_valid) begin
      rcv_codeword.bits <= enc_codeword.bits ^ mask_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rcv_valid <= 1'b0;
    end else begin
      rcv_valid <= enc_valid;
    end
  end

endmodule

`default_nettype wire

//--- hdl/secded_decoder.sv
// secded decoder, two stages
`timescale 1ns/1ps
`default_nettype none
`include "ecc_macros.svh"

module secded_decoder (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rcv_valid,
  input  ecc_types_pkg::codeword_u rcv_codeword,
  output logic                     dec_valid,
  output logic [`ECC_DATA_W-1:0]   dec_data,
  output logic                     dec_error_ce,
  output logic                     dec_error_due,
  output ecc_types_pkg::syndrome_t dec_error_syndrome
);

  // stage 1 registers
  logic                     s1_valid;
  ecc_types_pkg::codeword_u s1_cw;
  ecc_types_pkg::syndrome_t s1_syn;

  // stage 2 decode
  logic [`ECC_CW_W-1:0]     hit;
  logic [`ECC_CW_W-1:0]     flip;
  logic                     syn_nz;
  logic                     syn_odd;
  logic                     is_ce;
  logic                     is_due;
  ecc_types_pkg::codeword_u corrected;

  // stage 1, syndrome alongside the received word
  always_ff @(posedge clk) begin
    if (rcv_valid) begin
      s1_cw  <= rcv_codeword;
      s1_syn <= ecc_code_pkg::calc_syndrome(rcv_codeword.bits);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= rcv_valid;
    end
  end

  // column match, at most one hit since columns are distinct
  always_comb begin
    for (int i = 0; i < `ECC_CW_W; i++) begin
      hit[i] = (s1_syn == ecc_code_pkg::HCOL[i]);
    end
    syn_nz  = |s1_syn;
    syn_odd = ^s1_syn;
    // odd weight and a matching column means single error
    is_ce   = syn_odd && (|hit);
    // even nonzero, or odd with no column, is uncorrectable
    is_due  = syn_nz && !is_ce;
    // due words go through untouched
    flip           = is_ce ? hit : '0;
    corrected.bits = s1_cw.bits ^ flip;
  end

  // stage 2 payload
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      dec_data           <= corrected.f.data;
      dec_error_syndrome <= s1_syn;
    end
  end

  // flags only ever high together with dec_valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid     <= 1'b0;
      dec_error_ce  <= 1'b0;
      dec_error_due <= 1'b0;
    end else begin
      dec_valid     <= s1_valid;
      dec_error_ce  <= s1_valid && is_ce;
      dec_error_due <= s1_valid && is_due;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ecc_integrity_monitor.sv
// ecc channel integrity monitor
`timescale 1ns/1ps
`default_nettype none
`include "ecc_macros.svh"

module ecc_integrity_monitor (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   data_valid,
  input  logic [`ECC_DATA_W-1:0] data,
  input  logic                   dec_valid,
  input  logic [`ECC_DATA_W-1:0] dec_data,
  input  logic                   dec_error_ce,
  input  logic                   dec_error_due,
  output logic [`ECC_CNT_W-1:0]  ce_count,
  output logic [`ECC_CNT_W-1:0]  due_count,
  output logic                   sdc_seen
);

  // sent data, delayed to line up with dec_valid
  logic [`ECC_DATA_W-1:0]      data_dly [`ECC_PIPE_LATENCY];
  logic [`ECC_PIPE_LATENCY-1:0] valid_dly;
  logic [`ECC_DATA_W-1:0]      exp_data;
  logic                        exp_valid;
  logic                        silent_bad;

  // shifts every cycle, latency is fixed
  always_ff @(posedge clk) begin
    data_dly[0] <= data;
    for (int i = 1; i < `ECC_PIPE_LATENCY; i++) begin
      data_dly[i] <= data_dly[i-1];
    end
  end

  assign exp_data  = data_dly[`ECC_PIPE_LATENCY-1];
  assign exp_valid = valid_dly[`ECC_PIPE_LATENCY-1];

  // unflagged word that does not match what was sent
  assign silent_bad = dec_valid && exp_valid && !dec_error_ce && !dec_error_due &&
                      (dec_data != exp_data);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_dly <= '0;
      ce_count  <= '0;
      due_count <= '0;
      sdc_seen  <= 1'b0;
    end else begin
      valid_dly <= {valid_dly[`ECC_PIPE_LATENCY-2:0], data_valid};
      // counters hold at all ones
      if (dec_valid && dec_error_ce && (ce_count != '1)) begin
        ce_count <= ce_count + 1'b1;
      end
      if (dec_valid && dec_error_due && (due_count != '1)) begin
        due_count <= due_count + 1'b1;
      end
      // sticky until reset
      if (silent_bad) begin
        sdc_seen <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/ecc_channel_top.sv
// secded protection channel
`timescale 1ns/1ps
`default_nettype none
`include "ecc_macros.svh"

module ecc_channel_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     data_valid,
  input  logic [`ECC_DATA_W-1:0]   data,
  input  logic [`ECC_CW_W-1:0]     flip_mask,
  output logic                     dec_valid,
  output logic [`ECC_DATA_W-1:0]   dec_data,
  output logic                     dec_error_ce,
  output logic                     dec_error_due,
  output ecc_types_pkg::syndrome_t dec_error_syndrome,
  output logic [`ECC_CNT_W-1:0]    ce_count,
  output logic [`ECC_CNT_W-1:0]    due_count,
  output logic                     sdc_seen
);

  // encoder to injector
  logic                     enc_valid;
  ecc_types_pkg::codeword_u enc_codeword;
  // injector to decoder
  logic                     rcv_valid;
  ecc_types_pkg::codeword_u rcv_codeword;

  secded_encoder u_encoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_valid   (data_valid),
    .data         (data),
    .enc_valid    (enc_valid),
    .enc_codeword (enc_codeword)
  );

  // mask sampled with data, applied one cycle later
  error_injector u_injector (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_valid   (data_valid),
    .flip_mask    (flip_mask),
    .enc_valid    (enc_valid),
    .enc_codeword (enc_codeword),
    .rcv_valid    (rcv_valid),
    .rcv_codeword (rcv_codeword)
  );

  secded_decoder u_decoder (
    .clk                (clk),
    .rst_n              (rst_n),
    .rcv_valid          (rcv_valid),
    .rcv_codeword       (rcv_codeword),
    .dec_valid          (dec_valid),
    .dec_data           (dec_data),
    .dec_error_ce       (dec_error_ce),
    .dec_error_due      (dec_error_due),
    .dec_error_syndrome (dec_error_syndrome)
  );

  // checks decoder output against the sent word
  ecc_integrity_monitor u_monitor (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_valid    (data_valid),
    .data          (data),
    .dec_valid     (dec_valid),
    .dec_data      (dec_data),
    .dec_error_ce  (dec_error_ce),
    .dec_error_due (dec_error_due),
    .ce_count      (ce_count),
    .due_count     (due_count),
    .sdc_seen      (sdc_seen)
  );

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // held low through the first 4 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/ecc_channel_tb.sv
// ecc channel testbench
`timescale 1ns/1ps
`default_nettype none
`include "ecc_macros.svh"

module ecc_channel_tb;

  localparam int LATENCY     = 4;
  localparam int DRAIN_LIMIT = 64;
  localparam int RESET_LIMIT = 20;

  // one word in flight and what should come back
  typedef struct packed {
    logic [`ECC_DATA_W-1:0] data;
    logic [`ECC_CW_W-1:0]   mask;
    logic [`ECC_DATA_W-1:0] exp_data;
    logic                   ce;
    logic                   due;
    logic [31:0]            cycle;
  } word_t;

  logic                     clk;
  logic                     rst_n;
  logic                     data_valid;
  logic [`ECC_DATA_W-1:0]   data;
  logic [`ECC_CW_W-1:0]     flip_mask;
  logic                     dec_valid;
  logic [`ECC_DATA_W-1:0]   dec_data;
  logic                     dec_error_ce;
  logic                     dec_error_due;
  ecc_types_pkg::syndrome_t dec_error_syndrome;
  logic [`ECC_CNT_W-1:0]    ce_count;
  logic [`ECC_CNT_W-1:0]    due_count;
  logic                     sdc_seen;

  // vectors from the file, and words still in the pipe
  word_t       vec_q[$];
  word_t       exp_q[$];
  word_t       head;
  logic [31:0] cycle = '0;
  // checker errors and run errors kept apart, one writer each
  int          chk_err = 0;
  int          run_err = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          test_fail = 0;
  int          tally_ce = 0;
  int          tally_due = 0;
  int          err_base = 0;

  clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ecc_channel_top uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .data_valid         (data_valid),
    .data               (data),
    .flip_mask          (flip_mask),
    .dec_valid          (dec_valid),
    .dec_data           (dec_data),
    .dec_error_ce       (dec_error_ce),
    .dec_error_due      (dec_error_due),
    .dec_error_syndrome (dec_error_syndrome),
    .ce_count           (ce_count),
    .due_count          (due_count),
    .sdc_seen           (sdc_seen)
  );

  // cycle count for the latency check
  always @(posedge clk) begin
    cycle <= cycle + 32'd1;
  end

  // outputs sampled mid-cycle, well away from the edge
  always @(negedge clk) begin
    if (dec_valid) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: dec_valid with no word outstanding", $time);
        chk_err++;
      end else begin
        head = exp_q.pop_front();
        check_count++;
        if (dec_data !== head.exp_data) begin
          $display("MISMATCH t=%0t: data got %h want %h (sent %h mask %h)", $time,
                   dec_data, head.exp_data, head.data, head.mask);
          chk_err++;
        end
        if (dec_error_ce !== head.ce || dec_error_due !== head.due) begin
          $display("MISMATCH t=%0t: ce/due got %b/%b want %b/%b (mask %h syn %b)", $time,
                   dec_error_ce, dec_error_due, head.ce, head.due, head.mask,
                   dec_error_syndrome);
          chk_err++;
        end
        // zero only when clean and odd only for an odd flip count
        if ((dec_error_syndrome == '0) != (head.mask == '0) ||
            (^dec_error_syndrome) != (^head.mask)) begin
          $display("MISMATCH t=%0t: syndrome %b does not fit mask %h", $time,
                   dec_error_syndrome, head.mask);
          chk_err++;
        end
        // any fault must raise at least one flag
        if (head.mask != '0 && !dec_error_ce && !dec_error_due) begin
          $display("MISMATCH t=%0t: corrupted word came out unflagged (mask %h)", $time,
                   head.mask);
          chk_err++;
        end
        if ((cycle - head.cycle) != LATENCY) begin
          $display("MISMATCH t=%0t: latency got %0d cycles want %0d", $time,
                   cycle - head.cycle, LATENCY);
          chk_err++;
        end
      end
    end
  end

  // clean passes, one flip corrected, two flips flagged and passed through
  function automatic word_t predict(input word_t w);
    word_t r;
    r = w;
    case ($countones(w.mask))
      0: begin
        r.exp_data = w.data;
        r.ce       = 1'b0;
        r.due      = 1'b0;
      end
      1: begin
        r.exp_data = w.data;
        r.ce       = 1'b1;
        r.due      = 1'b0;
      end
      default: begin
        r.exp_data = w.data ^ w.mask[`ECC_DATA_W-1:0];
        r.ce       = 1'b0;
        r.due      = 1'b1;
      end
    endcase
    return r;
  endfunction

  // up to two distinct flipped positions
  function automatic logic [`ECC_CW_W-1:0] random_mask(input int flips);
    int                   a;
    int                   b;
    logic [`ECC_CW_W-1:0] m;
    m = '0;
    a = int'($urandom % `ECC_CW_W);
    b = (a + 1 + int'($urandom % (`ECC_CW_W - 1))) % `ECC_CW_W;
    if (flips >= 1) begin
      m[a] = 1'b1;
    end
    if (flips >= 2) begin
      m[b] = 1'b1;
    end
    return m;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    word_t       w;
    logic [31:0] f_data;
    logic [31:0] f_mask;
    logic [31:0] f_exp;
    logic [31:0] f_ce;
    logic [31:0] f_due;
    fd = $fopen("verif/ecc_testdata.txt", "r");
    if (fd == 0) begin
      $display("error: could not open verif/ecc_testdata.txt");
      run_err++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %h %h %h %h", f_data, f_mask, f_exp, f_ce, f_due);
      // comment and blank lines yield no fields
      if (n == 5) begin
        w          = '0;
        w.data     = f_data[`ECC_DATA_W-1:0];
        w.mask     = f_mask[`ECC_CW_W-1:0];
        w.exp_data = f_exp[`ECC_DATA_W-1:0];
        w.ce       = f_ce[0];
        w.due      = f_due[0];
        vec_q.push_back(w);
      end
    end
    $fclose(fd);
  endtask

  task automatic begin_test();
    err_base = chk_err + run_err;
  endtask

  task automatic end_test(input string name, input int words);
    int errs;
    errs = chk_err + run_err - err_base;
    test_count++;
    if (errs != 0) begin
      test_fail++;
    end
    $display("test %s: words=%0d errors=%0d %s", name, words, errs,
             (errs == 0) ? "ok" : "FAILED");
  endtask

  task automatic wait_reset();
    int guard;
    guard = 0;
    while (rst_n !== 1'b1 && guard < RESET_LIMIT) begin
      @(posedge clk);
      guard++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      run_err++;
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic drive_word(input word_t w);
    @(posedge clk);
    #1;
    data_valid = 1'b1;
    data       = w.data;
    flip_mask  = w.mask;
    w.cycle    = cycle;
    exp_q.push_back(w);
    if (w.ce) begin
      tally_ce++;
    end
    if (w.due) begin
      tally_due++;
    end
  endtask

  // go idle, then wait for every word to come out
  task automatic finish_burst(input string name);
    int guard;
    @(posedge clk);
    #1;
    data_valid = 1'b0;
    data       = '0;
    flip_mask  = '0;
    guard      = 0;
    while (exp_q.size() != 0 && guard < DRAIN_LIMIT) begin
      @(negedge clk);
      guard++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d words of %s never came out of the channel", exp_q.size(), name);
      run_err++;
      exp_q.delete();
    end
  endtask

  task automatic check_reset_state();
    begin_test();
    @(negedge clk);
    if (dec_valid !== 1'b0 || dec_error_ce !== 1'b0 || dec_error_due !== 1'b0) begin
      $display("MISMATCH t=%0t: valid or flags not low after reset", $time);
      run_err++;
    end
    if (ce_count !== '0 || due_count !== '0 || sdc_seen !== 1'b0) begin
      $display("MISMATCH t=%0t: monitor state not clear after reset", $time);
      run_err++;
    end
    end_test("reset_state", 0);
  endtask

  // file vectors with the given number of flipped bits
  task automatic run_file_group(input string name, input int ones);
    int                   n;
    logic [`ECC_CW_W-1:0] covered;
    n       = 0;
    covered = '0;
    begin_test();
    foreach (vec_q[i]) begin
      if ($countones(vec_q[i].mask) == ones) begin
        drive_word(vec_q[i]);
        covered = covered | vec_q[i].mask;
        n++;
      end
    end
    finish_burst(name);
    if (n == 0) begin
      $display("error: the test data holds no vectors for %s", name);
      run_err++;
    end
    if (ones == 1 && covered != '1) begin
      $display("error: single-bit vectors do not cover all codeword positions");
      run_err++;
    end
    end_test(name, n);
  endtask

  // back to back, either all double faults or a clean/single/double mix
  task automatic run_random(input string name, input int count, input bit mixed);
    word_t       w;
    int          flips;
    logic [31:0] r;
    begin_test();
    for (int i = 0; i < count; i++) begin
      flips  = mixed ? int'($urandom % 3) : 2;
      r      = $urandom;
      w      = '0;
      w.data = r[`ECC_DATA_W-1:0];
      w.mask = random_mask(flips);
      w      = predict(w);
      drive_word(w);
    end
    finish_burst(name);
    end_test(name, count);
  endtask

  task automatic check_counters();
    begin_test();
    // counters trail dec_valid by one cycle
    @(negedge clk);
    @(negedge clk);
    if (int'(ce_count) != tally_ce) begin
      $display("MISMATCH t=%0t: ce_count %0d want %0d", $time, ce_count, tally_ce);
      run_err++;
    end
    if (int'(due_count) != tally_due) begin
      $display("MISMATCH t=%0t: due_count %0d want %0d", $time, due_count, tally_due);
      run_err++;
    end
    if (sdc_seen !== 1'b0) begin
      $display("MISMATCH t=%0t: sdc_seen went high", $time);
      run_err++;
    end
    end_test("final_counters", 0);
  endtask

  initial begin
    data_valid = 1'b0;
    data       = '0;
    flip_mask  = '0;
    void'($urandom(32'h426dd4fb));
    load_vectors();
    wait_reset();
    check_reset_state();
    run_file_group("file_clean", 0);
    run_file_group("file_single", 1);
    run_file_group("file_double", 2);
    run_random("random_double", 200, 1'b0);
    run_file_group("file_triple", 3);
    run_random("back_to_back", 100, 1'b1);
    check_counters();
    $display("tests=%0d failed=%0d checks=%0d errors=%0d", test_count, test_fail,
             check_count, chk_err + run_err);
    if (chk_err + run_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/ecc_testdata.txt
// data mask exp_data ce due, all hex
// mask bit 0..7 data, 8..12 check bits
a5 0000 a5 0 0
00 0000 00 0 0
ff 0000 ff 0 0
3c 0001 3c 1 0
c3 0002 c3 1 0
5a 0004 5a 1 0
a5 0008 a5 1 0
96 0010 96 1 0
69 0020 69 1 0
0f 0040 0f 1 0
f0 0080 f0 1 0
01 0100 01 1 0
80 0200 80 1 0
7e 0400 7e 1 0
e7 0800 e7 1 0
55 1000 55 1 0
12 0003 11 0 1
6b 0180 eb 0 1
c4 1800 c4 0 1
5a 0700 5b 1 0
3c 000b 37 1 0
9d 1a00 9d 0 1

//--- list.f
+incdir+hdl
hdl/ecc_code_pkg.sv
hdl/ecc_types_pkg.sv
hdl/secded_encoder.sv
hdl/error_injector.sv
hdl/secded_decoder.sv
hdl/ecc_integrity_monitor.sv
hdl/ecc_channel_top.sv
verif/clk_gen.sv
verif/ecc_channel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ecc channel testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module ecc_channel_tb -o ecc_sim

# run, keep the log for the verdict
./obj_dir/ecc_sim > sim.log 2>&1
cat sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0
